/* fnd_counter.f */
src/fnd_pkg.sv
src/scan_tick_gen.sv
src/up_down_counter.sv
src/digit_scanner.sv
src/seg7_decoder.sv
src/fnd_counter_top.sv
dv/fnd_counter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fnd_counter simulation with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

rm -rf "${BUILD_DIR}" "${LOG_FILE}"

verilator --binary --timing -Wno-fatal \
    --top-module fnd_counter_tb \
    -f fnd_counter.f \
    -Mdir "${BUILD_DIR}" \
    -o fnd_counter_sim

"./${BUILD_DIR}/fnd_counter_sim" | tee "${LOG_FILE}"

if grep -qx "No errors" "${LOG_FILE}"; then
    echo "simulation passed, see ${LOG_FILE}"
else
    echo "simulation failed, see ${LOG_FILE}"
    exit 1
fi

/* dv/fnd_counter_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fnd_counter_tb;

    import fnd_pkg::*;

    localparam int COUNT_WIDTH  = 20;
    localparam int DIV_BITS     = 3;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MARGIN       = 50;
    localparam int NUM_ROWS     = 11;
    localparam int SCAN_HOLD    = 1 << DIV_BITS;   // clocks per digit

    typedef struct packed {
        logic        en;
        logic        du;       // 0 up, 1 down
        logic [15:0] cycles;   // zero draws a random length
    } stim_t;

    logic                     clk;
    logic                     reset_p;
    logic                     enable;
    logic                     down_up;
    logic [DISPLAY_WIDTH-1:0] count;
    logic [DIGIT_COUNT-1:0]   com;
    logic [SEG_WIDTH-1:0]     seg_7;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and expected segment patterns

    // holds of 16 shift the count against the scan by half a ring turn,
    // so digit 0 shows both even and odd values
    stim_t stim_table [NUM_ROWS] = '{
        '{1'b0, 1'b0, 16'd12},    // idle at zero
        '{1'b1, 1'b0, 16'd320},
        '{1'b0, 1'b0, 16'd16},
        '{1'b1, 1'b0, 16'd320},
        '{1'b0, 1'b1, 16'd0},
        '{1'b1, 1'b0, 16'd0},
        '{1'b0, 1'b0, 16'd16},
        '{1'b1, 1'b1, 16'd900},   // runs through zero into ffff
        '{1'b0, 1'b1, 16'd0},
        '{1'b1, 1'b1, 16'd0},
        '{1'b1, 1'b0, 16'd200}
    };

    logic [SEG_WIDTH-1:0] seg_table [16] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1011,
        8'b0000_0001, 8'b0001_1001, 8'b0001_0001, 8'b1100_0001,
        8'b0110_0011, 8'b1000_0101, 8'b0110_0001, 8'b0111_0001
    };

    // reference model state
    logic [COUNT_WIDTH-1:0]  m_cnt;
    logic [DIV_BITS-1:0]     m_div;
    logic                    m_cur;
    logic                    m_old;
    logic [DIGIT_COUNT-1:0]  m_com;
    logic [NIBBLE_WIDTH-1:0] m_dv;    // nibble picked one cycle back

    int          error_count = 0;
    int          check_count = 0;
    int          row_len [NUM_ROWS];
    int          total_cycles = 0;
    bit          plan_ready = 1'b0;
    logic [31:0] lfsr;
    bit          seen_digit [16];
    bit          seen_ffff = 1'b0;
    int          com_hold = 0;
    int          com_changes = 0;
    logic [3:0]  last_com = 4'b1110;

    fnd_counter_top #(
        .COUNT_WIDTH (COUNT_WIDTH),
        .DIV_BITS    (DIV_BITS)
    ) u_fnd_counter_top (
        .clk     (clk),
        .reset_p (reset_p),
        .enable  (enable),
        .down_up (down_up),
        .count   (count),
        .com     (com),
        .seg_7   (seg_7)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;   // x^32+x^22+x^2+x+1
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [3:0] next_com(input logic [3:0] cur);
        case (cur)
            4'b1110: return 4'b1101;
            4'b1101: return 4'b1011;
            4'b1011: return 4'b0111;
            default: return 4'b1110;   // 0111 wraps, anything else recovers
        endcase
    endfunction

    function automatic logic [3:0] pick_nibble(input logic [3:0] sel,
                                               input logic [15:0] shown);
        case (sel)
            4'b1101: return shown[7:4];
            4'b1011: return shown[11:8];
            4'b0111: return shown[15:12];
            default: return shown[3:0];
        endcase
    endfunction

    // advance the model across one rising edge
    task automatic model_step(input logic en, input logic du);
        logic tick;
        tick  = m_cur & ~m_old;
        m_dv  = pick_nibble(m_com, DISPLAY_WIDTH'(m_cnt >> (COUNT_WIDTH - DISPLAY_WIDTH)));
        if (tick) begin
            m_com = next_com(m_com);
        end
        m_old = m_cur;
        m_cur = m_div[DIV_BITS-1];
        m_div = m_div + DIV_BITS'(1);
        if (en) begin
            m_cnt = du ? m_cnt - COUNT_WIDTH'(1) : m_cnt + COUNT_WIDTH'(1);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("count", 32'(count), 32'(m_cnt >> (COUNT_WIDTH - DISPLAY_WIDTH)));
        check_value("com", 32'(com), 32'(m_com));
        check_value("seg_7", 32'(seg_7), 32'(seg_table[m_dv]));
        if (seg_7 === seg_table[m_dv]) begin
            seen_digit[m_dv] = 1'b1;
        end
        if (count === 16'hffff) begin
            seen_ffff = 1'b1;
        end
        // each select stays up for one full divider period
        if (com !== last_com) begin
            if (com_changes > 0 && com_hold != SCAN_HOLD) begin
                error_count++;
                $display("digit select %b stayed for %0d clocks instead of %0d",
                         last_com, com_hold, SCAN_HOLD);
            end
            com_changes++;
            com_hold = 1;
            last_com = com;
        end else begin
            com_hold++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int extra;
        reset_p = 1'b1;
        enable  = 1'b0;
        down_up = 1'b0;
        lfsr    = 32'hf52c4ad9;

        // fix every row length up front so the watchdog knows the run length
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (stim_table[r].cycles == 16'd0) begin
                draw_bits(6, extra);
                row_len[r] = 8 + extra;
            end else begin
                row_len[r] = int'(stim_table[r].cycles);
            end
            total_cycles += row_len[r];
        end
        plan_ready = 1'b1;

        m_cnt = '0;
        m_div = '0;
        m_cur = 1'b0;
        m_old = 1'b0;
        m_com = 4'b1110;
        m_dv  = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("count", 32'(count), 32'h0);
            check_value("com", 32'(com), 32'hE);
            check_value("seg_7", 32'(seg_7), 32'(seg_table[0]));
        end
        reset_p <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < row_len[r]; c++) begin
                enable  <= stim_table[r].en;
                down_up <= stim_table[r].du;
                @(negedge clk);
                model_step(stim_table[r].en, stim_table[r].du);
                check_outputs();
            end
        end

        for (int d = 0; d < 16; d++) begin
            if (!seen_digit[d]) begin
                error_count++;
                $display("hex digit %h never showed up on the segments", d);
            end
        end
        if (!seen_ffff) begin
            error_count++;
            $display("count never wrapped below zero to ffff");
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (plan_ready);
        #((total_cycles + RESET_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles",
                 total_cycles + RESET_CYCLES + MARGIN);
        $display("Errors found");
        $finish;
    end

endmodule : fnd_counter_tb

`default_nettype wire

/* src/fnd_counter_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fnd_counter_top #(
    parameter int COUNT_WIDTH = 32,   // at least DISPLAY_WIDTH
    parameter int DIV_BITS    = 17    // scan period is 2**DIV_BITS clocks
) (
    input  wire logic                         clk,
    input  wire logic                         reset_p,
    input  wire logic                         enable,
    input  wire logic                         down_up,
    output logic [fnd_pkg::DISPLAY_WIDTH-1:0] count,
    output logic [fnd_pkg::DIGIT_COUNT-1:0]   com,
    output logic [fnd_pkg::SEG_WIDTH-1:0]     seg_7
);

    import fnd_pkg::*;

    logic                    scan_tick;
    logic [NIBBLE_WIDTH-1:0] digit_value;

    ////////////////////////////////////////////////////////////////////////////
    // value to show

    up_down_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_up_down_counter (
        .clk     (clk),
        .reset_p (reset_p),
        .enable  (enable),
        .down_up (down_up),
        .count   (count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // multiplexed display path

    scan_tick_gen #(
        .DIV_BITS (DIV_BITS)
    ) u_scan_tick_gen (
        .clk       (clk),
        .reset_p   (reset_p),
        .scan_tick (scan_tick)
    );

    digit_scanner u_digit_scanner (
        .clk         (clk),
        .reset_p     (reset_p),
        .scan_tick   (scan_tick),
        .count       (count),
        .com         (com),
        .digit_value (digit_value)
    );

    seg7_decoder u_seg7_decoder (
        .digit_value (digit_value),
        .seg_7       (seg_7)         // decoded straight from the registered nibble
    );

endmodule : fnd_counter_top

`default_nettype wire

/* src/seg7_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module seg7_decoder (
    input  wire logic [fnd_pkg::NIBBLE_WIDTH-1:0] digit_value,
    output logic [fnd_pkg::SEG_WIDTH-1:0]         seg_7
);

    import fnd_pkg::*;

    // bit order is a,b,c,d,e,f,g then dp in bit 0
    // a zero lights the segment, dp always stays off
    always_comb begin
        case (digit_value)
            4'h0:    seg_7 = 8'b0000_0011;
            4'h1:    seg_7 = 8'b1001_1111;
            4'h2:    seg_7 = 8'b0010_0101;
            4'h3:    seg_7 = 8'b0000_1101;
            4'h4:    seg_7 = 8'b1001_1001;
            4'h5:    seg_7 = 8'b0100_1001;
            4'h6:    seg_7 = 8'b0100_0001;
            4'h7:    seg_7 = 8'b0001_1011;
            4'h8:    seg_7 = 8'b0000_0001;
            4'h9:    seg_7 = 8'b0001_1001;
            4'ha:    seg_7 = 8'b0001_0001;
            4'hb:    seg_7 = 8'b1100_0001;   // lower case b
            4'hc:    seg_7 = 8'b0110_0011;
            4'hd:    seg_7 = 8'b1000_0101;   // lower case d
            4'he:    seg_7 = 8'b0110_0001;
            4'hf:    seg_7 = 8'b0111_0001;
            default: seg_7 = SEG_BLANK;      // x or z on the input
        endcase
    end

endmodule : seg7_decoder

`default_nettype wire

/* src/digit_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module digit_scanner (
    input  wire logic                         clk,
    input  wire logic                         reset_p,
    input  wire logic                         scan_tick,
    input  wire logic [fnd_pkg::DISPLAY_WIDTH-1:0] count,
    output logic [fnd_pkg::DIGIT_COUNT-1:0]   com,
    output logic [fnd_pkg::NIBBLE_WIDTH-1:0]  digit_value
);

    import fnd_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // rotating digit select, one step per scan tick

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com <= COM_RESET;
        end else if (scan_tick) begin
            case (com)
                COM_DIG0: com <= COM_DIG1;
                COM_DIG1: com <= COM_DIG2;
                COM_DIG2: com <= COM_DIG3;
                COM_DIG3: com <= COM_DIG0;
                default:  com <= COM_RESET;   // recover from an illegal pattern
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // nibble of the selected digit, registered every clock

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            digit_value <= '0;
        end else begin
            case (com)
                COM_DIG0: digit_value <= count[0*NIBBLE_WIDTH +: NIBBLE_WIDTH];
                COM_DIG1: digit_value <= count[1*NIBBLE_WIDTH +: NIBBLE_WIDTH];
                COM_DIG2: digit_value <= count[2*NIBBLE_WIDTH +: NIBBLE_WIDTH];
                COM_DIG3: digit_value <= count[3*NIBBLE_WIDTH +: NIBBLE_WIDTH];
                default:  digit_value <= count[0 +: NIBBLE_WIDTH];
            endcase
        end
    end

    // digit_value trails com and count by one clock, so the segment
    // pattern lines up with the select one cycle late

endmodule : digit_scanner

`default_nettype wire

/* src/up_down_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module up_down_counter #(
    parameter int COUNT_WIDTH = 32
) (
    input  wire logic                        clk,
    input  wire logic                        reset_p,
    input  wire logic                        enable,
    input  wire logic                        down_up,   // 0 counts up, 1 counts down
    output logic [fnd_pkg::DISPLAY_WIDTH-1:0] count
);

    import fnd_pkg::*;

    logic [COUNT_WIDTH-1:0] count_full;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            count_full <= '0;
        end else if (enable) begin
            if (down_up) begin
                count_full <= count_full - 1'b1;   // wraps below zero
            end else begin
                count_full <= count_full + 1'b1;
            end
        end
    end

    // only the slow upper bits go to the display, the low bits
    // change far too quickly to be readable
    assign count = count_full[COUNT_WIDTH-1 -: DISPLAY_WIDTH];

endmodule : up_down_counter

`default_nettype wire

/* src/scan_tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_tick_gen #(
    parameter int DIV_BITS = 17
) (
    input  wire logic clk,
    input  wire logic reset_p,
    output logic      scan_tick
);

    logic [DIV_BITS-1:0] clk_div;   // free-running divider
    logic                ff_cur;
    logic                ff_old;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clk_div <= '0;
        end else begin
            clk_div <= clk_div + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // rising-edge detect on the divider msb

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            ff_cur <= 1'b0;
            ff_old <= 1'b0;
        end else begin
            ff_cur <= clk_div[DIV_BITS-1];  // sample the slow square wave
            ff_old <= ff_cur;               // one clock older copy
        end
    end

    // high for one clock per divider period, used as an enable
    // instead of clocking logic from clk_div directly
    assign scan_tick = ff_cur & ~ff_old;

endmodule : scan_tick_gen

`default_nettype wire

/* src/fnd_pkg.sv */
`default_nettype none

package fnd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // display geometry

    localparam int DISPLAY_WIDTH = 16;   // bits shown on the four digits
    localparam int DIGIT_COUNT   = 4;
    localparam int NIBBLE_WIDTH  = 4;    // one hex digit
    localparam int SEG_WIDTH     = 8;    // a..g plus decimal point

    ////////////////////////////////////////////////////////////////////////////
    // active-low digit selects, in scan order

    localparam logic [DIGIT_COUNT-1:0] COM_DIG0 = 4'b1110;  // lowest digit
    localparam logic [DIGIT_COUNT-1:0] COM_DIG1 = 4'b1101;
    localparam logic [DIGIT_COUNT-1:0] COM_DIG2 = 4'b1011;
    localparam logic [DIGIT_COUNT-1:0] COM_DIG3 = 4'b0111;  // highest digit

    // scan starts on the lowest digit
    localparam logic [DIGIT_COUNT-1:0] COM_RESET = COM_DIG0;

    // segments are active low, so all ones leaves the digit dark
    localparam logic [SEG_WIDTH-1:0] SEG_BLANK = 8'b1111_1111;

endpackage : fnd_pkg

`default_nettype wire
